// ==== design/pi_cfg_pkg.sv ====
package pi_cfg_pkg;

    ////////////////////////////////////////////////////////////////////
    // Interpolator geometry
    ////////////////////////////////////////////////////////////////////
    localparam int N_UNIT     = 32;                 // Delay units in the chain
    localparam int N_IDX      = $clog2(N_UNIT);     // Unit index width
    localparam int N_CODE     = 9;                  // Phase code width
    localparam int N_FINE     = 4;                  // Fine field, blender steps
    localparam int N_CRS      = N_CODE - N_FINE;    // Coarse field
    localparam int N_THM      = 16;                 // Blender thermometer
    localparam int N_PM       = 20;                 // Phase monitor accumulator

    // Cycles to let the arbiter settle before it is sampled
    localparam int CAL_SETTLE = 4;

    ////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////
    typedef logic [N_CODE-1:0] ctl_code_t;          // [8:4] coarse, [3:0] fine
    typedef logic [N_IDX-1:0]  unit_idx_t;          // Also carries Qperi
    typedef logic [N_UNIT-1:0] unit_vec_t;          // One bit per delay unit
    typedef logic [N_THM-1:0]  thm_bld_t;
    typedef logic [N_PM-1:0]   pm_count_t;

    // Highest Qperi the unit count can express
    localparam unit_idx_t QP_SAT = unit_idx_t'(N_UNIT - 1);

endpackage

// ==== design/pi_ctl_pkg.sv ====
package pi_ctl_pkg;

    // Qperi calibration sequence
    typedef enum logic [1:0] {
        CAL_IDLE   = 2'b00,
        CAL_SETTLE = 2'b01,     // Waiting for arb_out to settle
        CAL_SAMPLE = 2'b10,
        CAL_DONE   = 2'b11
    } cal_state_t;

    // Phase monitor sign select, matches sel_pm_sign encoding
    typedef enum logic [1:0] {
        PM_HOLD  = 2'b00,
        PM_ADD   = 2'b01,
        PM_SUB   = 2'b10,
        PM_CLEAR = 2'b11
    } pm_sign_t;

endpackage

// ==== design/pi_qperi_cal.sv ====
`timescale 1ns/1ps

module pi_qperi_cal (
    input  logic                  and_ph_out_d,
    input  logic                  rstb,
    input  logic                  en_cal,
    input  pi_cfg_pkg::unit_vec_t arb_out,
    input  logic                  en_ext_Qperi,
    input  pi_cfg_pkg::unit_idx_t ext_Qperi,
    output pi_cfg_pkg::unit_idx_t Qperi,
    output pi_cfg_pkg::unit_idx_t max_sel_mux,
    output logic                  cal_done
);

    pi_ctl_pkg::cal_state_t                    state;
    logic                                      en_cal_d;
    logic [$clog2(pi_cfg_pkg::CAL_SETTLE)-1:0] settle_cnt;
    logic [pi_cfg_pkg::N_IDX:0]                arb_ones;     // 0..32
    pi_cfg_pkg::unit_idx_t                     qperi_sat;
    pi_cfg_pkg::unit_idx_t                     qperi_meas;   // Last measured value
    logic [pi_cfg_pkg::N_IDX+1:0]              qperi_x4;
    pi_cfg_pkg::unit_idx_t                     max_next;

    ////////////////////////////////////////////////////////////////////
    // Arbiter thermometer count and wrap limit
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        arb_ones = '0;
        for (int i = 0; i < pi_cfg_pkg::N_UNIT; i++)
            arb_ones = arb_ones + arb_out[i];
        qperi_sat = (arb_ones > pi_cfg_pkg::QP_SAT) ? pi_cfg_pkg::QP_SAT
                                                     : arb_ones[pi_cfg_pkg::N_IDX-1:0];

        // Four quarter periods per period, last usable unit is one below
        qperi_x4 = {Qperi, 2'b00};
        if (Qperi == '0)
            max_next = '0;
        else if (qperi_x4 > pi_cfg_pkg::N_UNIT)
            max_next = pi_cfg_pkg::QP_SAT;
        else
            max_next = pi_cfg_pkg::unit_idx_t'(qperi_x4 - 1'b1);
    end

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            state       <= pi_ctl_pkg::CAL_IDLE;
            en_cal_d    <= 1'b0;
            settle_cnt  <= '0;
            qperi_meas  <= '0;
            Qperi       <= '0;
            max_sel_mux <= '0;
        end else begin
            en_cal_d <= en_cal;
            case (state)
                pi_ctl_pkg::CAL_IDLE: begin
                    if (en_cal && !en_cal_d) begin   // Start on rising level
                        state      <= pi_ctl_pkg::CAL_SETTLE;
                        settle_cnt <= '0;
                    end
                end
                pi_ctl_pkg::CAL_SETTLE: begin
                    if (!en_cal)
                        state <= pi_ctl_pkg::CAL_IDLE;
                    else if (settle_cnt == pi_cfg_pkg::CAL_SETTLE - 1)
                        state <= pi_ctl_pkg::CAL_SAMPLE;
                    else
                        settle_cnt <= settle_cnt + 1'b1;
                end
                pi_ctl_pkg::CAL_SAMPLE: state <= pi_ctl_pkg::CAL_DONE;
                pi_ctl_pkg::CAL_DONE: begin
                    if (!en_cal)
                        state <= pi_ctl_pkg::CAL_IDLE;
                end
                default: state <= pi_ctl_pkg::CAL_IDLE;
            endcase

            if (state == pi_ctl_pkg::CAL_SAMPLE)
                qperi_meas <= qperi_sat;

            // Override sits on top, the measurement is kept below it
            if (en_ext_Qperi)
                Qperi <= ext_Qperi;
            else if (state == pi_ctl_pkg::CAL_SAMPLE)
                Qperi <= qperi_sat;
            else
                Qperi <= qperi_meas;

            max_sel_mux <= max_next;                 // One cycle behind Qperi
        end
    end

    assign cal_done = (state == pi_ctl_pkg::CAL_DONE);

endmodule

// ==== design/pi_code_decode.sv ====
`timescale 1ns/1ps

module pi_code_decode (
    input  logic                  and_ph_out_d,
    input  logic                  rstb,
    input  logic                  ctl_valid,
    input  pi_cfg_pkg::ctl_code_t ctl,
    input  pi_cfg_pkg::unit_idx_t max_sel_mux,
    output pi_cfg_pkg::unit_idx_t unit_idx,
    output pi_cfg_pkg::thm_bld_t  thm_raw
);

    logic [pi_cfg_pkg::N_CRS-1:0]  coarse;
    logic [pi_cfg_pkg::N_FINE-1:0] fine;
    logic [pi_cfg_pkg::N_IDX:0]    wrap_diff;    // Extra bit flags underflow
    pi_cfg_pkg::unit_idx_t         idx_next;
    pi_cfg_pkg::thm_bld_t          thm_next;

    ////////////////////////////////////////////////////////////////////
    // Code split and coarse wrap
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        coarse    = ctl[pi_cfg_pkg::N_CODE-1:pi_cfg_pkg::N_FINE];
        fine      = ctl[pi_cfg_pkg::N_FINE-1:0];
        wrap_diff = {1'b0, coarse} - {1'b0, max_sel_mux} - 1'b1;

        // Codes beyond the calibrated period fold back by one period
        if (coarse <= max_sel_mux)
            idx_next = coarse;
        else if (wrap_diff[pi_cfg_pkg::N_IDX])
            idx_next = '0;
        else
            idx_next = wrap_diff[pi_cfg_pkg::N_IDX-1:0];

        // Fine steps light the low blender legs, top leg stays off
        thm_next = (pi_cfg_pkg::thm_bld_t'(1) << fine) - 1'b1;
    end

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            unit_idx <= '0;
            thm_raw  <= '0;
        end else if (ctl_valid) begin       // Hold until the next valid code
            unit_idx <= idx_next;
            thm_raw  <= thm_next;
        end
    end

endmodule

// ==== design/pi_phase_select.sv ====
`timescale 1ns/1ps

module pi_phase_select (
    input  logic                  and_ph_out_d,
    input  logic                  rstb,
    input  pi_cfg_pkg::unit_idx_t unit_idx,
    input  pi_cfg_pkg::thm_bld_t  thm_raw,
    input  pi_cfg_pkg::unit_idx_t max_sel_mux,
    output pi_cfg_pkg::unit_vec_t en_mixer,
    output pi_cfg_pkg::unit_idx_t sel_unit_even,
    output pi_cfg_pkg::unit_idx_t sel_unit_odd,
    output pi_cfg_pkg::thm_bld_t  thm_sel_bld,
    output pi_cfg_pkg::thm_bld_t  thm_sel_bld_d
);

    pi_cfg_pkg::unit_idx_t idx_adj;     // Neighbour unit, second blender input
    pi_cfg_pkg::unit_vec_t en_next;

    ////////////////////////////////////////////////////////////////////
    // Adjacent unit pair
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        if (unit_idx >= max_sel_mux)
            idx_adj = '0;               // Last unit of the period wraps to 0
        else
            idx_adj = unit_idx + 1'b1;

        en_next = (pi_cfg_pkg::unit_vec_t'(1) << unit_idx) |
                  (pi_cfg_pkg::unit_vec_t'(1) << idx_adj);
    end

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            en_mixer      <= '0;
            sel_unit_even <= '0;
            sel_unit_odd  <= '0;
            thm_sel_bld   <= '0;
            thm_sel_bld_d <= '0;
        end else begin
            en_mixer <= en_next;

            // Even units feed one mux tree, odd units the other
            if (unit_idx[0]) begin
                sel_unit_even <= idx_adj;
                sel_unit_odd  <= unit_idx;
            end else begin
                sel_unit_even <= unit_idx;
                sel_unit_odd  <= idx_adj;
            end

            thm_sel_bld   <= thm_raw;       // Resampled on the output clock
            thm_sel_bld_d <= thm_sel_bld;
        end
    end

endmodule

// ==== design/pi_phase_monitor.sv ====
`timescale 1ns/1ps

module pi_phase_monitor (
    input  logic                  and_ph_out_d,
    input  logic                  rstb,
    input  logic                  en_pm,
    input  logic [1:0]            sel_pm_sign,
    input  pi_cfg_pkg::unit_idx_t sel_unit_even,
    input  pi_cfg_pkg::thm_bld_t  thm_sel_bld,
    output pi_cfg_pkg::pm_count_t pm_out
);

    logic [pi_cfg_pkg::N_FINE:0] thm_ones;
    pi_cfg_pkg::pm_count_t       pos;
    pi_ctl_pkg::pm_sign_t        pm_sign;

    assign pm_sign = pi_ctl_pkg::pm_sign_t'(sel_pm_sign);

    ////////////////////////////////////////////////////////////////////
    // Delivered phase position
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        thm_ones = '0;
        for (int i = 0; i < pi_cfg_pkg::N_THM; i++)
            thm_ones = thm_ones + thm_sel_bld[i];
        // Coarse unit in blender steps plus the fine legs that are on
        pos = (pi_cfg_pkg::pm_count_t'(sel_unit_even) << pi_cfg_pkg::N_FINE) +
              pi_cfg_pkg::pm_count_t'(thm_ones);
    end

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            pm_out <= '0;
        end else if (en_pm) begin
            case (pm_sign)
                pi_ctl_pkg::PM_ADD:   pm_out <= pm_out + pos;   // Wraps mod 2^20
                pi_ctl_pkg::PM_SUB:   pm_out <= pm_out - pos;
                pi_ctl_pkg::PM_CLEAR: pm_out <= '0;
                default:              pm_out <= pm_out;
            endcase
        end
    end

endmodule

// ==== design/pi_ctrl_top.sv ====
`timescale 1ns/1ps

module pi_ctrl_top (
    input  logic                  and_ph_out_d,
    input  logic                  rstb,
    input  logic                  ctl_valid,
    input  pi_cfg_pkg::ctl_code_t ctl,
    input  logic                  en_cal,
    input  pi_cfg_pkg::unit_vec_t arb_out,
    input  logic                  en_ext_Qperi,
    input  pi_cfg_pkg::unit_idx_t ext_Qperi,
    input  logic                  en_pm,
    input  logic [1:0]            sel_pm_sign,
    output pi_cfg_pkg::unit_idx_t Qperi,
    output pi_cfg_pkg::unit_idx_t max_sel_mux,
    output pi_cfg_pkg::unit_vec_t en_mixer,
    output pi_cfg_pkg::unit_idx_t sel_unit_even,
    output pi_cfg_pkg::unit_idx_t sel_unit_odd,
    output pi_cfg_pkg::thm_bld_t  thm_sel_bld,
    output pi_cfg_pkg::thm_bld_t  thm_sel_bld_d,
    output logic                  cal_done,
    output pi_cfg_pkg::pm_count_t pm_out
);

    pi_cfg_pkg::unit_idx_t unit_idx;
    pi_cfg_pkg::thm_bld_t  thm_raw;

    pi_qperi_cal iqperi_cal (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .en_cal       (en_cal),
        .arb_out      (arb_out),
        .en_ext_Qperi (en_ext_Qperi),
        .ext_Qperi    (ext_Qperi),
        .Qperi        (Qperi),
        .max_sel_mux  (max_sel_mux),
        .cal_done     (cal_done)
    );

    pi_code_decode icode_decode (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .ctl_valid    (ctl_valid),
        .ctl          (ctl),
        .max_sel_mux  (max_sel_mux),
        .unit_idx     (unit_idx),
        .thm_raw      (thm_raw)
    );

    pi_phase_select iphase_select (
        .and_ph_out_d  (and_ph_out_d),
        .rstb          (rstb),
        .unit_idx      (unit_idx),
        .thm_raw       (thm_raw),
        .max_sel_mux   (max_sel_mux),
        .en_mixer      (en_mixer),
        .sel_unit_even (sel_unit_even),
        .sel_unit_odd  (sel_unit_odd),
        .thm_sel_bld   (thm_sel_bld),
        .thm_sel_bld_d (thm_sel_bld_d)
    );

    pi_phase_monitor iphase_monitor (
        .and_ph_out_d  (and_ph_out_d),
        .rstb          (rstb),
        .en_pm         (en_pm),
        .sel_pm_sign   (sel_pm_sign),
        .sel_unit_even (sel_unit_even),
        .thm_sel_bld   (thm_sel_bld),
        .pm_out        (pm_out)
    );

endmodule

// ==== dv/pi_ctrl_model.svh ====
`ifndef PI_CTRL_MODEL_SVH
`define PI_CTRL_MODEL_SVH

function automatic int ones32(input logic [31:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 32; i++)
        n += v[i];
    return n;
endfunction

// Quarter period from the arbiter sample, 31 at most
function automatic int qperi_of(input logic [31:0] arb);
    int n;
    n = ones32(arb);
    return (n > 31) ? 31 : n;
endfunction

function automatic int limit_of(input int qp);
    if (qp == 0)
        return 0;
    return (4 * qp - 1 > 31) ? 31 : 4 * qp - 1;
endfunction

function automatic int wrap_unit(input int coarse, input int lim);
    if (coarse <= lim)
        return coarse;
    return (coarse - lim - 1 < 0) ? 0 : coarse - lim - 1;
endfunction

function automatic int next_unit(input int idx, input int lim);
    return (idx >= lim) ? 0 : idx + 1;       // Past the period limit goes to unit 0
endfunction

function automatic logic [15:0] thermo(input int fine);
    logic [15:0] t;
    t = '0;
    for (int i = 0; i < fine; i++)
        t[i] = 1'b1;
    return t;
endfunction

function automatic int position(input int even, input logic [15:0] thm);
    return even * 16 + ones32({16'h0, thm});
endfunction

`endif

// ==== dv/pi_ctrl_tb.sv ====
`timescale 1ns/1ps

module pi_ctrl_tb;

    logic                  and_ph_out_d;
    logic                  rstb;
    logic                  ctl_valid;
    pi_cfg_pkg::ctl_code_t ctl;
    logic                  en_cal;
    pi_cfg_pkg::unit_vec_t arb_out;
    logic                  en_ext_Qperi;
    pi_cfg_pkg::unit_idx_t ext_Qperi;
    logic                  en_pm;
    logic [1:0]            sel_pm_sign;
    pi_cfg_pkg::unit_idx_t Qperi;
    pi_cfg_pkg::unit_idx_t max_sel_mux;
    pi_cfg_pkg::unit_vec_t en_mixer;
    pi_cfg_pkg::unit_idx_t sel_unit_even;
    pi_cfg_pkg::unit_idx_t sel_unit_odd;
    pi_cfg_pkg::thm_bld_t  thm_sel_bld;
    pi_cfg_pkg::thm_bld_t  thm_sel_bld_d;
    logic                  cal_done;
    pi_cfg_pkg::pm_count_t pm_out;

    logic [31:0] seed = 32'h25ca;
    int          n_checks, n_errors, test_err, n_tests;
    bit          timed_out;
    int          q_set [6] = '{1, 2, 3, 5, 8, 0};   // Arbiter counts for the decode runs

    // Reference state: decode stage, execute stage, accumulator
    int          dec_idx;
    logic [15:0] dec_thm;
    int          exp_qp;
    int          exp_lim;
    logic [31:0] exp_en;
    int          exp_even;
    int          exp_odd;
    logic [15:0] exp_thm;
    logic [15:0] exp_thm_d;
    logic [19:0] exp_pm;

    `include "pi_ctrl_model.svh"

    pi_ctrl_top dut0 (.*);

    initial begin
        and_ph_out_d = 1'b0;
        forever #20 and_ph_out_d = ~and_ph_out_d;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rnd();
        logic [31:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = {seed[31:16], 16'h0};
        seed = seed * 32'd1664525 + 32'd1013904223;
        return hi | seed[31:16];            // High halves only, low LCG bits are weak
    endfunction

    function automatic logic [31:0] therm_arb(input int n);
        return (n >= 32) ? 32'hffff_ffff : (32'd1 << n) - 1;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_err++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-12s %0d errors", name, test_err);
        test_err = 0;
        n_tests++;
    endtask

    task automatic exec_from_dec();
        int adj;
        adj      = next_unit(dec_idx, exp_lim);
        exp_en   = (32'd1 << dec_idx) | (32'd1 << adj);
        exp_even = (dec_idx % 2 == 1) ? adj : dec_idx;
        exp_odd  = (dec_idx % 2 == 1) ? dec_idx : adj;
        exp_thm  = dec_thm;
    endtask

    // One clock of the reference, inputs were applied at the last falling edge
    task automatic step_cycle();
        @(negedge and_ph_out_d);
        if (en_pm) begin
            case (sel_pm_sign)
                2'b01:   exp_pm = exp_pm + position(exp_even, exp_thm);
                2'b10:   exp_pm = exp_pm - position(exp_even, exp_thm);
                2'b11:   exp_pm = '0;
                default: exp_pm = exp_pm;
            endcase
        end
        exp_thm_d = exp_thm;
        exec_from_dec();
        if (ctl_valid) begin
            dec_idx = wrap_unit(ctl[8:4], exp_lim);
            dec_thm = thermo(ctl[3:0]);
        end
        check_val("en_mixer", en_mixer, exp_en);
        check_val("sel_unit_even", sel_unit_even, exp_even);
        check_val("sel_unit_odd", sel_unit_odd, exp_odd);
        check_val("thm_sel_bld", thm_sel_bld, exp_thm);
        check_val("thm_sel_bld_d", thm_sel_bld_d, exp_thm_d);
        check_val("pm_out", pm_out, exp_pm);
    endtask

    task automatic run_cal(input logic [31:0] arb);
        int cnt;
        arb_out = arb;
        en_cal  = 1'b1;
        cnt     = 0;
        while (!cal_done && cnt < 20) begin
            @(negedge and_ph_out_d);
            cnt++;
        end
        if (!cal_done) begin
            $display("Timeout: cal_done did not rise within 20 cycles of en_cal");
            timed_out = 1'b1;
            n_errors++;
            return;
        end
        check_val("cal_latency", cnt, pi_cfg_pkg::CAL_SETTLE + 2);
        exp_qp = qperi_of(arb);
        check_val("Qperi", Qperi, exp_qp);
        @(negedge and_ph_out_d);
        exp_lim = limit_of(exp_qp);
        check_val("max_sel_mux", max_sel_mux, exp_lim);   // One cycle behind Qperi
        en_cal = 1'b0;
        cnt    = 0;
        while (cal_done && cnt < 20) begin
            @(negedge and_ph_out_d);
            cnt++;
        end
        if (cal_done) begin
            $display("Timeout: cal_done stayed high after en_cal fell");
            timed_out = 1'b1;
            n_errors++;
        end
    endtask

    task automatic run_stream(input int cycles, input bit with_pm);
        repeat (2) @(negedge and_ph_out_d);
        exec_from_dec();                    // Pipeline is idle, both stages hold dec state
        exp_thm_d = dec_thm;
        for (int i = 0; i < cycles; i++) begin
            ctl_valid = (rnd() % 4) != 0;
            ctl       = pi_cfg_pkg::ctl_code_t'(rnd());
            if (with_pm) begin
                en_pm       = (rnd() % 3) != 0;
                sel_pm_sign = (rnd() % 16 == 0) ? 2'b11 : 2'(rnd() % 3);
            end
            step_cycle();
        end
        ctl_valid = 1'b0;
        en_pm     = 1'b0;
        step_cycle();
        step_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int prev;
        rstb         = 1'b0;
        ctl_valid    = 1'b0;
        ctl          = '0;
        en_cal       = 1'b0;
        arb_out      = '0;
        en_ext_Qperi = 1'b0;
        ext_Qperi    = '0;
        en_pm        = 1'b0;
        sel_pm_sign  = 2'b00;
        dec_idx      = 0;
        dec_thm      = '0;
        exp_pm       = '0;
        exp_lim      = 0;
        exp_qp       = 0;
        repeat (10) @(negedge and_ph_out_d);

        check_val("Qperi", Qperi, 0);
        check_val("max_sel_mux", max_sel_mux, 0);
        check_val("en_mixer", en_mixer, 0);
        check_val("sel_unit_even", sel_unit_even, 0);
        check_val("sel_unit_odd", sel_unit_odd, 0);
        check_val("thm_sel_bld", thm_sel_bld, 0);
        check_val("thm_sel_bld_d", thm_sel_bld_d, 0);
        check_val("cal_done", cal_done, 0);
        check_val("pm_out", pm_out, 0);
        rstb = 1'b1;
        end_test("reset");

        for (int i = 0; i < 6 && !timed_out; i++)
            run_cal((i == 0) ? 32'hffff_ffff : (rnd() % 2) ? rnd() : therm_arb(rnd() % 33));
        end_test("calibration");

        if (!timed_out) begin
            prev = exp_qp;
            for (int i = 0; i < 8; i++) begin
                en_ext_Qperi = 1'b1;
                ext_Qperi    = pi_cfg_pkg::unit_idx_t'(rnd());
                @(negedge and_ph_out_d);
                check_val("Qperi", Qperi, ext_Qperi);
                check_val("max_sel_mux", max_sel_mux, limit_of(prev));
                prev = ext_Qperi;
            end
            en_ext_Qperi = 1'b0;
            @(negedge and_ph_out_d);
            check_val("Qperi", Qperi, exp_qp);     // Measured value comes back
            check_val("max_sel_mux", max_sel_mux, limit_of(prev));
            @(negedge and_ph_out_d);
            check_val("max_sel_mux", max_sel_mux, exp_lim);
            end_test("override");
        end

        for (int k = 0; k < 6 && !timed_out; k++) begin
            run_cal(therm_arb(q_set[k]));
            if (!timed_out)
                run_stream(60, 1'b0);
        end
        end_test("decode");

        if (!timed_out) begin
            run_cal(therm_arb(6));
            if (!timed_out)
                run_stream(200, 1'b1);
            end_test("monitor");
        end

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0 && !timed_out)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== pi_ctrl_top.f ====
+incdir+dv
design/pi_cfg_pkg.sv
design/pi_ctl_pkg.sv
design/pi_qperi_cal.sv
design/pi_code_decode.sv
design/pi_phase_select.sv
design/pi_phase_monitor.sv
design/pi_ctrl_top.sv
dv/pi_ctrl_tb.sv
